// ==== rtl/renamer_pkg.sv ====
// ===================================================================
// renamer package: register counts, register-number types and the
// result record handed back for every accepted rename
// ===================================================================
package renamer_pkg;

   // ===================================================================
   // sizes
   // ===================================================================
   localparam int PREGS      = 64;              // physical registers in the file
   localparam int AREGS      = 16;              // architectural registers seen by software
   localparam int NBANKS     = 4;               // free-list banks, one per low-bit pattern
   localparam int BANK_DEPTH = PREGS / NBANKS;  // every register of a bank fits at once

   // ===================================================================
   // register-number types
   // ===================================================================
   typedef logic [$clog2(PREGS)-1:0]  pregno_t;   // physical register number
   typedef logic [$clog2(AREGS)-1:0]  aregno_t;   // architectural register number
   typedef logic [$clog2(NBANKS)-1:0] bankno_t;   // free-list bank index

   // the three physical registers reported one cycle after a rename
   // is accepted; old_preg is what commit later hands back to the free list
   typedef struct packed {
      pregno_t src_preg;   // current home of the source operand
      pregno_t new_preg;   // freshly allocated home of the destination
      pregno_t old_preg;   // previous home of the destination
   } rename_result_t;

endpackage

// ==== rtl/free_list_if.sv ====
`timescale 1ns/100ps
// ===================================================================
// free-list bank interface: push, pop, head and status of one bank
// ===================================================================
interface free_list_if import renamer_pkg::*; ();

   logic    push;        // return a register to the bank
   pregno_t push_preg;   // the register being returned
   logic    pop;         // take the head, valid in the same cycle
   pregno_t head;        // oldest free register, shown without a read delay
   logic    empty;       // nothing to allocate
   logic    full;        // every register of the bank is free
   logic    busy;        // still seeding after reset, no traffic allowed

   // the bank side owns the storage and reports status
   modport fifo (
      input  push,
      input  push_preg,
      input  pop,
      output head,
      output empty,
      output full,
      output busy
   );

   // the controller side decides when to pop and where frees go
   modport ctrl (
      output push,
      output push_preg,
      output pop,
      input  head,
      input  empty,
      input  full,
      input  busy
   );

endinterface

// ==== rtl/free_list_fifo.sv ====
`timescale 1ns/100ps
// ===================================================================
// free-list bank: first-word-fall-through register FIFO of physical
// register numbers, loads its own share of free registers after reset
// ===================================================================
module free_list_fifo import renamer_pkg::*; #(
   parameter int BANK = 0   // bank index, every register here has number % NBANKS == BANK
) (
   input logic       clk,
   input logic       rst_n,
   free_list_if.fifo fl
);

   localparam int SEEDS  = (PREGS - AREGS) / NBANKS;   // free registers per bank at reset
   localparam int PTR_W  = $clog2(BANK_DEPTH);
   localparam int CNT_W  = $clog2(BANK_DEPTH + 1);
   localparam int SEED_W = $clog2(SEEDS);

   pregno_t           mem [BANK_DEPTH];   // the storage array
   logic [PTR_W-1:0]  wr_ptr;             // next slot to fill
   logic [PTR_W-1:0]  rd_ptr;             // slot shown on head
   logic [CNT_W-1:0]  count;              // registers currently held
   logic [SEED_W-1:0] seed_cnt;           // how many seeds are in so far
   logic              busy;               // high until seeding is done
   pregno_t           seed_preg;          // register number being seeded
   logic              wr_en;
   logic              rd_en;
   pregno_t           wr_data;

   // ===================================================================
   // seeding
   // ===================================================================
   // registers below AREGS start out mapped, so the first seed of this bank
   // is AREGS+BANK and each later one is NBANKS further on
   assign seed_preg = pregno_t'(AREGS + BANK) + pregno_t'(NBANKS * seed_cnt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         seed_cnt <= '0;
         busy     <= 1'b1;
      end else if (busy) begin
         seed_cnt <= seed_cnt + 1'b1;   // one seed per cycle
         if (seed_cnt == SEED_W'(SEEDS - 1))
            busy <= 1'b0;               // last seed goes in on this edge
      end
   end

   // ===================================================================
   // storage and pointers
   // ===================================================================
   // the seed counter owns the write port while busy, outside traffic is
   // dropped then, as it is when the request would over- or underflow
   assign wr_en   = busy | (fl.push & ~fl.full);
   assign wr_data = busy ? seed_preg : fl.push_preg;
   assign rd_en   = fl.pop & ~fl.empty & ~busy;

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two so pointers just wrap
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or neither leaves the fill level alone
         endcase
      end
   end

   // ===================================================================
   // status towards the controller
   // ===================================================================
   assign fl.head  = mem[rd_ptr];                      // fall-through, popped value is seen now
   assign fl.empty = (count == '0);
   assign fl.full  = (count == CNT_W'(BANK_DEPTH));
   assign fl.busy  = busy;

   // ===================================================================
   // checks
   // ===================================================================
   // a pop on an empty bank would give the same register to two destinations
   a_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
      fl.pop |-> !fl.empty)
      else $error("free_list_fifo %0d: pop while empty", BANK);

   // a push on a full bank means some register was freed twice
   a_push_full : assert property (@(posedge clk) disable iff (!rst_n)
      fl.push |-> !fl.full)
      else $error("free_list_fifo %0d: push while full", BANK);

endmodule

// ==== rtl/rename_map.sv ====
`timescale 1ns/100ps
// ===================================================================
// rename map: architectural to physical register table, two
// combinational read ports and one write port
// ===================================================================
module rename_map import renamer_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  aregno_t src_areg,    // source operand lookup
   output pregno_t src_preg,
   input  aregno_t dst_areg,    // destination lookup and write address
   output pregno_t old_preg,
   input  logic    wr_en,
   input  pregno_t wr_preg      // new home of dst_areg
);

   pregno_t map [AREGS];   // one physical register per architectural one
   logic    wr_dup;        // the written register already backs another entry

   // ===================================================================
   // table
   // ===================================================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int k = 0; k < AREGS; k++)
            map[k] <= pregno_t'(k);   // identity mapping out of reset
      end else if (wr_en) begin
         map[dst_areg] <= wr_preg;    // visible to the next request
      end
   end

   // both reads see the table before this cycle's write, so a request
   // whose source equals its destination gets the old mapping for both
   assign src_preg = map[src_areg];
   assign old_preg = map[dst_areg];

   // ===================================================================
   // checks
   // ===================================================================
   always_comb begin
      wr_dup = 1'b0;
      for (int k = 0; k < AREGS; k++) begin
         if (aregno_t'(k) != dst_areg && map[k] == wr_preg)
            wr_dup = 1'b1;   // two architectural registers would share storage
      end
   end

   // the free lists and this table must never both own a register, so a
   // register coming out of a bank can't be live in any other entry
   a_wr_dup : assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !wr_dup)
      else $error("rename_map: preg %0d written to areg %0d is mapped elsewhere",
                  wr_preg, dst_areg);

endmodule

// ==== rtl/rename_ctrl.sv ====
`timescale 1ns/100ps
// ===================================================================
// rename controller: picks a bank round-robin, pops it, updates the
// map, routes freed registers home and registers the rename result
// ===================================================================
module rename_ctrl import renamer_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   free_list_if.ctrl      fl [NBANKS],
   input  logic           ren_valid,
   input  aregno_t        ren_src,
   input  aregno_t        ren_dst,
   input  logic           free_valid,
   input  pregno_t        free_preg,
   output aregno_t        map_src_areg,
   input  pregno_t        map_src_preg,
   output aregno_t        map_dst_areg,
   input  pregno_t        map_old_preg,
   output logic           map_wr_en,
   output pregno_t        map_wr_preg,
   output logic           ren_stall,
   output logic           ready,
   output logic           out_valid,
   output rename_result_t out_result
);

   logic [NBANKS-1:0] bank_empty;
   logic [NBANKS-1:0] bank_busy;
   pregno_t           bank_head [NBANKS];
   logic [NBANKS-1:0] pop_vec;
   logic [NBANKS-1:0] push_vec;
   bankno_t           rr_ptr;        // where the next search starts
   bankno_t           sel_bank;      // bank that serves this cycle's rename
   bankno_t           free_bank;     // home bank of the registered free
   logic              accept;        // rename taken at this edge
   logic              free_v_q;
   pregno_t           free_preg_q;
   logic              renamed_any;   // at least one rename since reset

   // ===================================================================
   // bank fan-out
   // ===================================================================
   for (genvar g = 0; g < NBANKS; g++) begin : g_bank
      assign bank_empty[g]   = fl[g].empty;
      assign bank_busy[g]    = fl[g].busy;
      assign bank_head[g]    = fl[g].head;
      assign pop_vec[g]      = accept && (sel_bank == bankno_t'(g));
      assign push_vec[g]     = free_v_q && (free_bank == bankno_t'(g));
      assign fl[g].pop       = pop_vec[g];
      assign fl[g].push      = push_vec[g];
      assign fl[g].push_preg = free_preg_q;   // only the addressed bank takes it
   end

   // ready follows the banks directly, all of them come out of reset busy
   assign ready     = ~|bank_busy;
   assign ren_stall = ~ready | (&bank_empty);   // nothing to hand out
   assign accept    = ren_valid & ~ren_stall;

   // first non-empty bank at or after the pointer, the pointer itself if
   // every bank is empty, which only happens while stalled
   always_comb begin
      bankno_t idx;
      logic    found;
      sel_bank = rr_ptr;
      found    = 1'b0;
      for (int i = 0; i < NBANKS; i++) begin
         idx = rr_ptr + bankno_t'(i);   // wraps around the bank count
         if (!found && !bank_empty[idx]) begin
            sel_bank = idx;
            found    = 1'b1;
         end
      end
   end

   // ===================================================================
   // map access
   // ===================================================================
   assign map_src_areg = ren_src;
   assign map_dst_areg = ren_dst;
   assign map_wr_en    = accept;
   assign map_wr_preg  = bank_head[sel_bank];   // head is live in the pop cycle

   // ===================================================================
   // control state
   // ===================================================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rr_ptr      <= '0;
         out_valid   <= 1'b0;
         free_v_q    <= 1'b0;
         renamed_any <= 1'b0;
      end else begin
         out_valid <= accept;     // one-cycle pulse per accepted rename
         free_v_q  <= free_valid;
         if (accept) begin
            rr_ptr      <= bankno_t'(sel_bank + 1'b1);   // start after the bank just used
            renamed_any <= 1'b1;
         end
      end
   end

   // result and free payload, qualified by out_valid and free_v_q
   always_ff @(posedge clk) begin
      free_preg_q <= free_preg;
      if (accept)
         out_result <= '{src_preg: map_src_preg,
                         new_preg: bank_head[sel_bank],
                         old_preg: map_old_preg};
   end

   assign free_bank = bankno_t'(free_preg_q);   // low bits name the home bank

   // ===================================================================
   // checks
   // ===================================================================
   // until something has been renamed every register below AREGS is still
   // the live home of its architectural register and can't be freed
   a_free_arch : assert property (@(posedge clk) disable iff (!rst_n)
      (free_valid && !renamed_any) |-> (free_preg >= pregno_t'(AREGS)))
      else $error("rename_ctrl: preg %0d freed before any rename", free_preg);

endmodule

// ==== rtl/renamer_top.sv ====
`timescale 1ns/100ps
// ===================================================================
// register renamer top: four free-list banks, the map table and the
// controller, with plain ports towards the core
// ===================================================================
module renamer_top import renamer_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    ren_valid,      // rename request strobe
   input  aregno_t ren_src,
   input  aregno_t ren_dst,
   input  logic    free_valid,     // commit returns a register
   input  pregno_t free_preg,
   output logic    ren_stall,      // hold the request while high
   output logic    out_valid,      // result pulse, one cycle after accept
   output pregno_t out_src_preg,
   output pregno_t out_new_preg,
   output pregno_t out_old_preg,
   output logic    ready           // seeding finished
);

   free_list_if    fl_if [NBANKS] ();   // one bundle per bank
   aregno_t        map_src_areg;
   aregno_t        map_dst_areg;
   pregno_t        map_src_preg;
   pregno_t        map_old_preg;
   logic           map_wr_en;
   pregno_t        map_wr_preg;
   rename_result_t out_result;

   // ===================================================================
   // free-list banks
   // ===================================================================
   for (genvar g = 0; g < NBANKS; g++) begin : g_bank
      free_list_fifo #(
         .BANK (g)
      ) bank_inst (
         .clk   (clk),
         .rst_n (rst_n),
         .fl    (fl_if[g])
      );
   end

   rename_map rename_map_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .src_areg (map_src_areg),
      .src_preg (map_src_preg),
      .dst_areg (map_dst_areg),
      .old_preg (map_old_preg),
      .wr_en    (map_wr_en),
      .wr_preg  (map_wr_preg)
   );

   rename_ctrl rename_ctrl_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .fl           (fl_if),
      .ren_valid    (ren_valid),
      .ren_src      (ren_src),
      .ren_dst      (ren_dst),
      .free_valid   (free_valid),
      .free_preg    (free_preg),
      .map_src_areg (map_src_areg),
      .map_src_preg (map_src_preg),
      .map_dst_areg (map_dst_areg),
      .map_old_preg (map_old_preg),
      .map_wr_en    (map_wr_en),
      .map_wr_preg  (map_wr_preg),
      .ren_stall    (ren_stall),
      .ready        (ready),
      .out_valid    (out_valid),
      .out_result   (out_result)
   );

   // split the registered result onto the three output buses
   assign out_src_preg = out_result.src_preg;
   assign out_new_preg = out_result.new_preg;
   assign out_old_preg = out_result.old_preg;

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/100ps
// ===================================================================
// testbench clock and reset: free-running clock, reset held low for
// a fixed number of rising edges
// ===================================================================
module tb_clkgen #(
   parameter int PERIOD       = 40,   // clock period in ns
   parameter int RESET_CYCLES = 2     // rising edges seen with rst_n low
) (
   output logic clk,
   output logic rst_n
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;   // released on an edge like any other input
   end

endmodule

// ==== verif/renamer_tb.sv ====
`timescale 1ns/100ps
// ===================================================================
// renamer testbench driving random renames and frees against a
// reference map, per-bank free counts and a set of registers in use
// ===================================================================
module renamer_tb import renamer_pkg::*; ();

   localparam int TIMEOUT     = 600;   // covers seeding, drain, frees and the mixed phase
   localparam int READY_LIMIT = 14;    // cycles from reset release to ready
   localparam int SEEDS       = (PREGS - AREGS) / NBANKS;

   logic        clk;
   logic        rst_n;
   logic        ren_valid;
   aregno_t     ren_src;
   aregno_t     ren_dst;
   logic        free_valid;
   pregno_t     free_preg;
   logic        ren_stall;
   logic        out_valid;
   pregno_t     out_src_preg;
   pregno_t     out_new_preg;
   pregno_t     out_old_preg;
   logic        ready;

   int          seed = 32'h30a2;
   int unsigned err_cnt = 0;
   int unsigned ren_cnt = 0;
   int unsigned free_cnt = 0;
   int          cycles;
   int          since_rst;       // cycles after reset release without ready
   logic        ready_seen;
   logic        ren_done = 1'b0;

   // ===================================================================
   // reference model
   // ===================================================================
   pregno_t          ref_map [AREGS];   // architectural to physical, as software sees it
   logic [PREGS-1:0] in_use;            // mapped, or retired but not yet freed
   int               bank_cnt [NBANKS]; // free registers per bank
   bankno_t          rr_ptr;
   pregno_t          retire_q [$];      // old mappings waiting to be freed
   logic             exp_v;             // a result is due at the next negedge
   pregno_t          exp_src;
   pregno_t          exp_old;
   aregno_t          exp_dst;
   bankno_t          exp_bank;
   logic             fp1_v;             // free seen one cycle ago
   pregno_t          fp1_p;
   logic             fp2_v;             // free pushed into its bank at the coming edge
   pregno_t          fp2_p;

   tb_clkgen #(.PERIOD(40), .RESET_CYCLES(2)) clkgen_inst (.clk(clk), .rst_n(rst_n));

   renamer_top renamer_top_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .ren_valid    (ren_valid),
      .ren_src      (ren_src),
      .ren_dst      (ren_dst),
      .free_valid   (free_valid),
      .free_preg    (free_preg),
      .ren_stall    (ren_stall),
      .out_valid    (out_valid),
      .out_src_preg (out_src_preg),
      .out_new_preg (out_new_preg),
      .out_old_preg (out_old_preg),
      .ready        (ready)
   );

   task automatic report_err(input string msg);
      err_cnt++;
      $display("ERR at %0t: %s", $time, msg);
   endtask

   // scan from the top down so the lowest offset from start wins
   function automatic bankno_t pick_bank(input bankno_t start);
      bankno_t idx;
      pick_bank = start;
      for (int i = NBANKS - 1; i >= 0; i--) begin
         idx = bankno_t'((int'(start) + i) % NBANKS);
         if (bank_cnt[idx] > 0)
            pick_bank = idx;
      end
   endfunction

   // ===================================================================
   // checker sampling all outputs at the falling edge
   // ===================================================================
   always @(negedge clk) begin : monitor
      bankno_t b;
      int      total;
      if (!rst_n) begin
         for (int k = 0; k < AREGS; k++)
            ref_map[k] = pregno_t'(k);   // identity map out of reset
         in_use = '0;
         for (int k = 0; k < AREGS; k++)
            in_use[k] = 1'b1;
         for (int k = 0; k < NBANKS; k++)
            bank_cnt[k] = SEEDS;
         rr_ptr     = '0;
         exp_v      = 1'b0;
         fp1_v      = 1'b0;
         fp2_v      = 1'b0;
         since_rst  = 0;
         ready_seen = 1'b0;
         retire_q.delete();
         assert (ren_stall && !out_valid && !ready)
            else report_err("stall low, out_valid or ready high in reset");
      end else begin
         if (fp2_v) begin                           // landed in its bank at the last edge
            bank_cnt[int'(fp2_p) % NBANKS]++;
            in_use[fp2_p] = 1'b0;
         end
         fp2_v = fp1_v;
         fp2_p = fp1_p;
         fp1_v = 1'b0;
         if (exp_v) begin
            assert (out_valid) else report_err("no out_valid one cycle after an accepted rename");
            assert (out_src_preg == exp_src)
               else report_err($sformatf("src preg %0d, expected %0d", out_src_preg, exp_src));
            assert (out_old_preg == exp_old)
               else report_err($sformatf("old preg %0d, expected %0d", out_old_preg, exp_old));
            assert (!in_use[out_new_preg])
               else report_err($sformatf("new preg %0d is still mapped or in flight", out_new_preg));
            assert (int'(out_new_preg) % NBANKS == int'(exp_bank))
               else report_err($sformatf("new preg %0d, expected one from bank %0d",
                                         out_new_preg, exp_bank));
            ref_map[exp_dst]    = out_new_preg;
            in_use[out_new_preg] = 1'b1;
            retire_q.push_back(exp_old);   // commit will hand it back later
            ren_cnt++;
         end else begin
            assert (!out_valid) else report_err("out_valid without an accepted rename");
         end
         exp_v = 1'b0;
         if (ready) begin
            ready_seen = 1'b1;
         end else begin
            since_rst++;
            assert (!ready_seen) else report_err("ready dropped after seeding");
            assert (since_rst <= READY_LIMIT) else report_err("ready late after reset");
         end
         total = 0;
         for (int k = 0; k < NBANKS; k++)
            total += bank_cnt[k];
         assert (ren_stall == (!ready || total == 0))
            else report_err($sformatf("ren_stall %0b with %0d free registers", ren_stall, total));
         if (ren_valid && !ren_stall) begin         // accepted at the next rising edge
            b        = pick_bank(rr_ptr);
            exp_src  = ref_map[ren_src];            // both lookups before the update
            exp_old  = ref_map[ren_dst];
            exp_dst  = ren_dst;
            exp_bank = b;
            exp_v    = 1'b1;
            bank_cnt[b]--;
            rr_ptr   = bankno_t'(b + 1'b1);
         end
         if (free_valid) begin
            fp1_v = 1'b1;
            fp1_p = free_preg;
         end
      end
   end

   // ===================================================================
   // stimulus
   // ===================================================================
   // holds the request until the renamer takes it, returns on that edge
   task automatic rename_one(input aregno_t s, input aregno_t d);
      ren_valid <= 1'b1;
      ren_src   <= s;
      ren_dst   <= d;
      @(negedge clk);
      while (ren_stall)
         @(negedge clk);
      @(posedge clk);
   endtask

   // every bank is empty and a request is held while this runs
   task automatic free_into_empty(input pregno_t p);
      @(posedge clk);
      free_valid <= 1'b1;
      free_preg  <= p;
      free_cnt++;
      @(negedge clk);
      assert (ren_stall) else report_err("stall cleared before the free was registered");
      @(posedge clk);
      free_valid <= 1'b0;
      @(negedge clk);
      assert (ren_stall) else report_err("stall cleared before the freed register reached its bank");
      @(negedge clk);
      assert (!ren_stall) else report_err("freed register did not clear the stall");
      @(negedge clk);
      assert (out_valid && out_new_preg == p)
         else report_err($sformatf("new preg %0d, expected the freed preg %0d", out_new_preg, p));
   endtask

   initial begin : stimulus
      ren_valid  = 1'b0;
      ren_src    = '0;
      ren_dst    = '0;
      free_valid = 1'b0;
      free_preg  = '0;
      wait (rst_n === 1'b1);
      @(posedge clk);
      // the first request is held through seeding, every bank drains after 48
      repeat (PREGS - AREGS) rename_one(aregno_t'($random(seed)), aregno_t'($random(seed)));
      @(negedge clk);                               // result of the last rename
      repeat (10) begin
         @(negedge clk);
         assert (ren_stall && !out_valid) else report_err("rename accepted with every bank drained");
      end
      repeat (NBANKS) free_into_empty(retire_q.pop_front());
      @(posedge clk);
      fork
         begin
            repeat (60) rename_one(aregno_t'($random(seed)), aregno_t'($random(seed)));
            ren_valid <= 1'b0;
            @(negedge clk);
            ren_done = 1'b1;
         end
         begin
            int slot;
            slot = 0;
            while (!ren_done) begin
               @(posedge clk);
               slot++;
               if (!ren_done && slot % 3 != 0 && retire_q.size() > 0) begin
                  free_valid <= 1'b1;               // two frees out of every three cycles
                  free_preg  <= retire_q.pop_front();
                  free_cnt++;
               end else begin
                  free_valid <= 1'b0;
               end
            end
         end
      join
      @(posedge clk);
      free_valid <= 1'b0;
      repeat (4) @(negedge clk);                    // let the last frees land
      $display("renames %0d, frees %0d, errors %0d", ren_cnt, free_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("renames %0d, frees %0d, errors %0d", ren_cnt, free_cnt, err_cnt);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== renamer.f ====
rtl/renamer_pkg.sv
rtl/free_list_if.sv
rtl/free_list_fifo.sv
rtl/rename_map.sv
rtl/rename_ctrl.sv
rtl/renamer_top.sv
verif/tb_clkgen.sv
verif/renamer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the renamer testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module renamer_tb -f renamer.f \
   -Mdir obj_dir -o renamer_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/renamer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Test failed$" "$LOG"; then
   exit 1
fi
exit 0
